/* src.f */
design/tpu_pkg.sv
design/unified_buffer.sv
design/act_feeder.sv
design/mac_column.sv
design/acc_bank.sv
design/tpu_sequencer.sv
design/tpu_top.sv
sim/tpu_checker.sv
sim/tb_tpu.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the testbench with Verilator, pass only if the log shows the pass line

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_tpu -Mdir obj_dir -f src.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/Vtb_tpu +verilator+error+limit+1000 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -qF '** PASS **' "$LOG"; then
    echo "Simulation passed"
    exit 0
fi
echo "Simulation failed, see $LOG"
exit 1

/* sim/tb_tpu.sv */
`timescale 1ns/100ps

module tb_tpu;

    import tpu_pkg::*;

    localparam int CLK_PERIOD   = 100;
    localparam int RESET_CYCLES = 16;
    localparam int PROG_ROWS    = 48;      // MATMUL and ST_UB rows of both programs
    localparam int LOAD_CYCLES  = 500;     // Host loads and reads, two cycles each
    localparam int WATCHDOG     = 200 * PROG_ROWS + LOAD_CYCLES + RESET_CYCLES;

    logic               clk;
    logic               reset;
    ub_wr_t             host_ub_wr;
    ub_rd_t             host_ub_rd;
    logic [ROW_W-1:0]   ub_rd_data;
    logic               ub_rd_valid;
    logic               wt_wr_en;
    logic [WT_AW-1:0]   wt_wr_addr;
    elem_t              wt_wr_data;
    logic               imem_wr_en;
    logic [IMEM_AW-1:0] imem_wr_addr;
    instr_u             imem_wr_data;
    logic               start;
    logic               busy;
    logic               done;

    logic [31:0]        lfsr;
    logic [ROW_W-1:0]   ub_model [UB_DEPTH];         // Host view of the buffer
    int                 wt_model [LANES][LANES];     // W[i][j]
    int                 acc_model [ACC_DEPTH][LANES];
    logic [ROW_W-1:0]   exp_q [$];                   // Rows owed by pending host reads
    int                 errors = 0;
    int                 checks = 0;
    int                 starts = 0;
    int                 done_count = 0;

    tpu_top u_dut (
        .clk          (clk),
        .reset        (reset),
        .host_ub_wr   (host_ub_wr),
        .host_ub_rd   (host_ub_rd),
        .ub_rd_data   (ub_rd_data),
        .ub_rd_valid  (ub_rd_valid),
        .wt_wr_en     (wt_wr_en),
        .wt_wr_addr   (wt_wr_addr),
        .wt_wr_data   (wt_wr_data),
        .imem_wr_en   (imem_wr_en),
        .imem_wr_addr (imem_wr_addr),
        .imem_wr_data (imem_wr_data),
        .start        (start),
        .busy         (busy),
        .done         (done)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // ==================================================================
    // Random source and reference model
    // ==================================================================
    function automatic logic [31:0] lfsr_step(logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);   // Right-shift Galois form
    endfunction

    task automatic take_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int k = 0; k < n; k++) begin
            v[k] = lfsr[0];
            lfsr = lfsr_step(lfsr);     // One step per bit
        end
    endtask

    task automatic small_signed(input int bits, output int v);
        logic [31:0] raw;
        take_bits(bits, raw);
        v = int'(raw) - (raw[bits-1] ? (1 << bits) : 0);     // Sign of the top bit taken
    endtask

    // Dot product of one activation row with weight column j
    function automatic int lane_dot(logic [ROW_W-1:0] act, int j);
        int s;
        s = 0;
        for (int i = 0; i < LANES; i++) begin
            s += int'($signed(act[ELEM_W*i +: ELEM_W])) * wt_model[i][j];
        end
        return s;
    endfunction

    function automatic logic [ELEM_W-1:0] sat_elem(int v);
        if (v > 127) return 8'h7f;
        if (v < -128) return 8'h80;
        return v[ELEM_W-1:0];
    endfunction

    function automatic logic [ROW_W-1:0] ref_row(int a);
        logic [ROW_W-1:0] r;
        for (int j = 0; j < LANES; j++) begin
            r[ELEM_W*j +: ELEM_W] = sat_elem(acc_model[a][j]);    // Lane j in byte j
        end
        return r;
    endfunction

    function automatic void model_matmul(int ub, int rows, int acc, logic clr);
        int a;
        for (int r = 0; r < rows; r++) begin
            a = (acc + r) % ACC_DEPTH;
            for (int j = 0; j < LANES; j++) begin
                acc_model[a][j] = lane_dot(ub_model[(ub + r) % UB_DEPTH], j)
                                  + (clr ? 0 : acc_model[a][j]);
            end
        end
    endfunction

    function automatic void model_store(int acc, int ub, int rows);
        for (int r = 0; r < rows; r++) begin
            ub_model[(ub + r) % UB_DEPTH] = ref_row((acc + r) % ACC_DEPTH);
        end
    endfunction

    // ==================================================================
    // Instruction words
    // ==================================================================
    function automatic instr_u mm_word(int ub, int rows, int acc, logic clr);
        instr_u w;
        w             = '0;
        w.mm.opcode   = OP_MATMUL;
        w.mm.ub_addr  = UB_AW'(ub);
        w.mm.rows     = 5'(rows);
        w.mm.acc_addr = ACC_AW'(acc);
        w.mm.clear    = clr;
        return w;
    endfunction

    function automatic instr_u st_word(int acc, int ub, int rows);
        instr_u w;
        w             = '0;
        w.st.opcode   = OP_ST_UB;
        w.st.acc_addr = ACC_AW'(acc);
        w.st.ub_addr  = UB_AW'(ub);
        w.st.rows     = 5'(rows);
        return w;
    endfunction

    function automatic instr_u halt_word();
        instr_u w;
        w           = '0;
        w.mm.opcode = OP_HALT;
        return w;
    endfunction

    // ==================================================================
    // Host tasks, each drives for one cycle on the falling edge
    // ==================================================================
    task automatic check_value(string what, logic [31:0] got, logic [31:0] want);
        checks++;
        assert (got === want) else begin
            errors++;
            $display("ERROR %0t ns: %s is %h, expected %h", $time, what, got, want);
        end
    endtask

    task automatic ub_write(int addr, logic [ROW_W-1:0] data);
        @(negedge clk);
        host_ub_wr.en   = 1'b1;
        host_ub_wr.addr = UB_AW'(addr);
        host_ub_wr.data = data;
        ub_model[addr]  = data;
        @(negedge clk);
        host_ub_wr.en   = 1'b0;
    endtask

    task automatic ub_read(int addr);
        @(negedge clk);
        host_ub_rd.en   = 1'b1;
        host_ub_rd.addr = UB_AW'(addr);
        exp_q.push_back(ub_model[addr]);
        @(negedge clk);
        host_ub_rd.en   = 1'b0;
    endtask

    task automatic wt_write(int i, int j, int v);
        @(negedge clk);
        wt_wr_en       = 1'b1;
        wt_wr_addr     = {2'(i), 2'(j)};   // Row index high, column low
        wt_wr_data     = v[ELEM_W-1:0];
        wt_model[i][j] = v;
        @(negedge clk);
        wt_wr_en       = 1'b0;
    endtask

    task automatic imem_write(int addr, instr_u w);
        @(negedge clk);
        imem_wr_en   = 1'b1;
        imem_wr_addr = IMEM_AW'(addr);
        imem_wr_data = w;
        @(negedge clk);
        imem_wr_en   = 1'b0;
    endtask

    task automatic load_small_rows(int base, int n);
        logic [ROW_W-1:0] row;
        int               v;
        for (int a = 0; a < n; a++) begin
            for (int e = 0; e < LANES; e++) begin
                small_signed(4, v);                   // Keeps most sums unsaturated
                row[ELEM_W*e +: ELEM_W] = v[ELEM_W-1:0];
            end
            ub_write(base + a, row);
        end
    endtask

    task automatic run_program();
        @(negedge clk);
        start = 1'b1;
        starts++;
        @(negedge clk);
        start = 1'b0;
        check_value("busy after start", busy, 1'b1);
        while (done !== 1'b1) @(negedge clk);
        check_value("busy with done", busy, 1'b0);
        @(negedge clk);
        check_value("done after pulse", done, 1'b0);
        check_value("busy after done", busy, 1'b0);
    endtask

    // ==================================================================
    // Read comparison and done monitor
    // ==================================================================
    always @(negedge clk) begin
        logic [ROW_W-1:0] exp_row;
        if (ub_rd_valid === 1'b1) begin
            assert (exp_q.size() > 0) else begin
                errors++;
                $display("Read data came back at %0t ns with no host read pending", $time);
            end
            if (exp_q.size() > 0) begin
                exp_row = exp_q.pop_front();
                check_value("buffer row", ub_rd_data, exp_row);
            end
        end
    end

    always @(negedge clk) begin
        if (done === 1'b1) begin
            done_count++;
        end
    end

    initial begin
        repeat (WATCHDOG) @(posedge clk);
        $display("Timeout: the run did not finish within %0d cycles", WATCHDOG);
        $display("** FAIL **");
        $finish;
    end

    // ==================================================================
    // Test sequence
    // ==================================================================
    initial begin
        logic [31:0] raw;
        int          v;
        clk          = 1'b0;
        reset        = 1'b1;
        host_ub_wr   = '0;
        host_ub_rd   = '0;
        wt_wr_en     = 1'b0;
        wt_wr_addr   = '0;
        wt_wr_data   = '0;
        imem_wr_en   = 1'b0;
        imem_wr_addr = '0;
        imem_wr_data = '0;
        start        = 1'b0;
        lfsr         = 32'h3de32c67;
        repeat (RESET_CYCLES) @(negedge clk);
        reset = 1'b0;
        @(negedge clk);
        check_value("busy after reset", busy, 1'b0);
        check_value("done after reset", done, 1'b0);
        check_value("rd_valid after reset", ub_rd_valid, 1'b0);

        // Round trip on rows no program touches
        for (int a = 128; a < 144; a++) begin
            take_bits(32, raw);
            ub_write(a, raw);
        end
        for (int a = 128; a < 144; a++) ub_read(a);

        // Program A, clear over live sums, then accumulate on the same rows
        for (int i = 0; i < LANES; i++) begin
            for (int j = 0; j < LANES; j++) begin
                small_signed(3, v);
                wt_write(i, j, v);
            end
        end
        load_small_rows(16, 8);
        load_small_rows(32, 8);
        imem_write(0, mm_word(32, 8, 0, 1'b1));    // Leaves nonzero sums behind
        imem_write(1, mm_word(16, 8, 0, 1'b1));    // Must overwrite them
        imem_write(2, st_word(0, 64, 8));
        imem_write(3, mm_word(32, 8, 0, 1'b0));
        imem_write(4, st_word(0, 80, 8));
        imem_write(5, '0);                         // NOP
        imem_write(6, halt_word());
        model_matmul(32, 8, 0, 1'b1);
        model_matmul(16, 8, 0, 1'b1);
        model_store(0, 64, 8);
        model_matmul(32, 8, 0, 1'b0);
        model_store(0, 80, 8);
        run_program();
        for (int a = 64; a < 72; a++) ub_read(a);
        for (int a = 80; a < 88; a++) ub_read(a);

        // Program B, large same-sign values, even columns positive
        for (int i = 0; i < LANES; i++) begin
            for (int j = 0; j < LANES; j++) begin
                wt_write(i, j, (j % 2 == 0) ? 127 : -127);
            end
        end
        ub_write(48, 32'h7f7f7f7f);
        ub_write(49, 32'h80808080);
        ub_write(50, 32'h7f5a647f);
        ub_write(51, 32'h90a0b0c0);
        imem_write(0, mm_word(48, 4, 8, 1'b1));
        imem_write(1, st_word(8, 96, 4));
        imem_write(2, halt_word());
        model_matmul(48, 4, 8, 1'b1);
        model_store(8, 96, 4);
        run_program();
        for (int a = 96; a < 100; a++) ub_read(a);

        repeat (2) @(negedge clk);                 // Last read data is compared
        check_value("done pulse count", done_count, starts);
        checks++;
        assert (exp_q.size() == 0) else begin
            errors++;
            $display("%0d host reads never returned data", exp_q.size());
        end
        $display("Checks: %0d  errors: %0d  checker failures: %0d",
                 checks, errors, u_dut.u_checker.fail_count);
        if (errors == 0 && u_dut.u_checker.fail_count == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

/* sim/tpu_checker.sv */
`timescale 1ns/100ps

module tpu_checker (
    input logic clk,
    input logic reset,
    input logic busy,
    input logic done,
    input logic host_rd_en,
    input logic rd_valid
);

    int fail_count = 0;     // Read by the testbench at the end

    // ==================================================================
    // Program control
    // ==================================================================
    a_busy_done_excl: assert property (@(posedge clk) disable iff (reset) !(busy && done))
        else begin
            $error("busy and done high in the same cycle");
            fail_count++;
        end

    a_done_pulse: assert property (@(posedge clk) disable iff (reset) done |=> !done)
        else begin
            $error("done held for more than one cycle");
            fail_count++;
        end

    a_idle_after_done: assert property (@(posedge clk) disable iff (reset) done |=> !busy)
        else begin
            $error("busy high right after done");
            fail_count++;
        end

    // Host read data one cycle after the request
    a_rd_follows: assert property (@(posedge clk) disable iff (reset) host_rd_en |=> rd_valid)
        else begin
            $error("host read without rd_valid on the next cycle");
            fail_count++;
        end

    a_rd_no_extra: assert property (@(posedge clk) disable iff (reset)
                                    rd_valid |-> $past(host_rd_en))
        else begin
            $error("rd_valid without a host read the cycle before");
            fail_count++;
        end

endmodule

bind tpu_top tpu_checker u_checker (
    .clk        (clk),
    .reset      (reset),
    .busy       (busy),
    .done       (done),
    .host_rd_en (host_ub_rd.en),
    .rd_valid   (ub_rd_valid)
);

/* design/tpu_top.sv */
`timescale 1ns/100ps

module tpu_top (
    input  logic                          clk,
    input  logic                          reset,
    // Host side of the buffer
    input  tpu_pkg::ub_wr_t               host_ub_wr,
    input  tpu_pkg::ub_rd_t               host_ub_rd,
    output logic [tpu_pkg::ROW_W-1:0]     ub_rd_data,
    output logic                          ub_rd_valid,
    // Weight and program load
    input  logic                          wt_wr_en,
    input  logic [tpu_pkg::WT_AW-1:0]     wt_wr_addr,
    input  tpu_pkg::elem_t                wt_wr_data,
    input  logic                          imem_wr_en,
    input  logic [tpu_pkg::IMEM_AW-1:0]   imem_wr_addr,
    input  tpu_pkg::instr_u               imem_wr_data,
    // Control and status
    input  logic                          start,
    output logic                          busy,
    output logic                          done
);

    import tpu_pkg::*;

    ub_rd_t                        seq_ub_rd;   // Sequencer read request
    mm_tag_t                       mm_tag;      // Travels with each MATMUL read
    acc_rd_t                       acc_rd;
    ub_wr_t                        st_wr;       // Saturated result row
    row_t                          row;         // Broadcast to every column
    psum_t                         psum;
    logic [LANES-1:0]              col_valid;
    logic [LANES-1:0][ACC_AW-1:0]  col_acc_addr;
    logic [LANES-1:0]              col_clear;

    tpu_sequencer u_seq (
        .clk          (clk),
        .reset        (reset),
        .imem_wr_en   (imem_wr_en),
        .imem_wr_addr (imem_wr_addr),
        .imem_wr_data (imem_wr_data),
        .start        (start),
        .seq_ub_rd    (seq_ub_rd),
        .mm_tag       (mm_tag),
        .acc_rd       (acc_rd),
        .busy         (busy),
        .done         (done)
    );

    unified_buffer u_ub (
        .clk      (clk),
        .reset    (reset),
        .host_wr  (host_ub_wr),
        .host_rd  (host_ub_rd),
        .seq_rd   (seq_ub_rd),
        .st_wr    (st_wr),
        .rd_data  (ub_rd_data),
        .rd_valid (ub_rd_valid)
    );

    act_feeder u_feeder (
        .clk      (clk),
        .reset    (reset),
        .rd_data  (ub_rd_data),
        .rd_valid (ub_rd_valid),
        .mm_tag   (mm_tag),
        .row      (row)
    );

    // ==================================================================
    // One column per output lane
    // ==================================================================
    for (genvar c = 0; c < LANES; c++) begin : g_col
        mac_column #(.COL(c)) u_col (
            .clk          (clk),
            .reset        (reset),
            .wt_wr_en     (wt_wr_en),
            .wt_wr_addr   (wt_wr_addr),
            .wt_wr_data   (wt_wr_data),
            .row          (row),
            .psum         (psum[c]),
            .out_valid    (col_valid[c]),
            .out_acc_addr (col_acc_addr[c]),
            .out_clear    (col_clear[c])
        );
    end

    acc_bank u_acc (
        .clk         (clk),
        .reset       (reset),
        .psum        (psum),
        .in_valid    (col_valid),
        .in_acc_addr (col_acc_addr),
        .in_clear    (col_clear),
        .acc_rd      (acc_rd),
        .st_wr       (st_wr)
    );

endmodule

/* design/tpu_sequencer.sv */
`timescale 1ns/100ps

module tpu_sequencer (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          imem_wr_en,
    input  logic [tpu_pkg::IMEM_AW-1:0]   imem_wr_addr,
    input  tpu_pkg::instr_u               imem_wr_data,
    input  logic                          start,
    output tpu_pkg::ub_rd_t               seq_ub_rd,
    output tpu_pkg::mm_tag_t              mm_tag,
    output tpu_pkg::acc_rd_t              acc_rd,
    output logic                          busy,
    output logic                          done
);

    import tpu_pkg::*;

    typedef enum logic [2:0] {
        S_IDLE,
        S_FETCH,
        S_ISSUE,    // One MATMUL row per cycle
        S_DRAIN,    // Let the last rows reach the accumulators
        S_STORE     // One ST_UB row per cycle
    } state_e;

    instr_u              imem [IMEM_DEPTH];
    instr_u              instr;
    state_e              state;
    logic [IMEM_AW-1:0]  pc;
    logic [4:0]          cnt;          // Rows left in this instruction
    logic [1:0]          drain_cnt;
    logic [UB_AW-1:0]    ub_addr_q;
    logic [ACC_AW-1:0]   acc_addr_q;
    logic                clear_q;

    // Program store, loaded by the host while idle
    always_ff @(posedge clk) begin
        if (imem_wr_en) begin
            imem[imem_wr_addr] <= imem_wr_data;
        end
    end

    assign instr = imem[pc];   // Fetch is combinational

    // ==================================================================
    // Control FSM
    // ==================================================================
    always_ff @(posedge clk) begin
        if (reset) begin
            state     <= S_IDLE;
            pc        <= '0;
            cnt       <= '0;
            drain_cnt <= '0;
            busy      <= 1'b0;
            done      <= 1'b0;
        end else begin
            done <= 1'b0;                                  // Single-cycle pulse
            case (state)
                S_IDLE: begin
                    if (start) begin
                        pc    <= '0;
                        busy  <= 1'b1;
                        state <= S_FETCH;
                    end
                end
                S_FETCH: begin
                    pc <= pc + 1'b1;
                    case (instr.mm.opcode)
                        OP_MATMUL: begin
                            ub_addr_q  <= instr.mm.ub_addr;
                            acc_addr_q <= instr.mm.acc_addr;
                            clear_q    <= instr.mm.clear;
                            cnt        <= instr.mm.rows;
                            state      <= S_ISSUE;
                        end
                        OP_ST_UB: begin                    // Same word, store view
                            ub_addr_q  <= instr.st.ub_addr;
                            acc_addr_q <= instr.st.acc_addr;
                            cnt        <= instr.st.rows;
                            state      <= S_STORE;
                        end
                        OP_HALT: begin
                            busy  <= 1'b0;                 // Falls with done
                            done  <= 1'b1;
                            state <= S_IDLE;
                        end
                        default: ;                         // NOP just steps the PC
                    endcase
                end
                S_ISSUE: begin
                    ub_addr_q  <= ub_addr_q + 1'b1;
                    acc_addr_q <= acc_addr_q + 1'b1;
                    cnt        <= cnt - 1'b1;
                    if (cnt == 5'd1) begin
                        drain_cnt <= 2'(DRAIN_CYCLES - 1);
                        state     <= S_DRAIN;
                    end
                end
                S_DRAIN: begin
                    drain_cnt <= drain_cnt - 1'b1;
                    if (drain_cnt == '0) begin
                        state <= S_FETCH;
                    end
                end
                S_STORE: begin
                    ub_addr_q  <= ub_addr_q + 1'b1;
                    acc_addr_q <= acc_addr_q + 1'b1;
                    cnt        <= cnt - 1'b1;
                    if (cnt == 5'd1) begin
                        state <= S_FETCH;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    // Requests come straight from the address registers
    assign seq_ub_rd.en     = (state == S_ISSUE);
    assign seq_ub_rd.addr   = ub_addr_q;
    assign mm_tag.valid     = (state == S_ISSUE);
    assign mm_tag.acc_addr  = acc_addr_q;
    assign mm_tag.clear     = clear_q;
    assign acc_rd.en        = (state == S_STORE);
    assign acc_rd.acc_addr  = acc_addr_q;
    assign acc_rd.ub_addr   = ub_addr_q;

endmodule

/* design/acc_bank.sv */
`timescale 1ns/100ps

module acc_bank (
    input  logic                                         clk,
    input  logic                                         reset,
    input  tpu_pkg::psum_t                               psum,
    input  logic [tpu_pkg::LANES-1:0]                    in_valid,
    input  logic [tpu_pkg::LANES-1:0][tpu_pkg::ACC_AW-1:0] in_acc_addr,
    input  logic [tpu_pkg::LANES-1:0]                    in_clear,
    input  tpu_pkg::acc_rd_t                             acc_rd,
    output tpu_pkg::ub_wr_t                              st_wr
);

    import tpu_pkg::*;

    psum_t             mem [ACC_DEPTH];
    psum_t             rd_row;
    elem_t [LANES-1:0] sat_row;

    // ==================================================================
    // Clear or accumulate, each lane from its own column
    // ==================================================================
    always_ff @(posedge clk) begin
        for (int l = 0; l < LANES; l++) begin
            if (in_valid[l]) begin
                if (in_clear[l]) begin
                    mem[in_acc_addr[l]][l] <= psum[l];
                end else begin
                    mem[in_acc_addr[l]][l] <= mem[in_acc_addr[l]][l] + psum[l];
                end
            end
        end
    end

    // ==================================================================
    // Store path, saturate to signed 8 bits
    // ==================================================================
    assign rd_row = mem[acc_rd.acc_addr];

    always_comb begin
        for (int l = 0; l < LANES; l++) begin
            if (rd_row[l] > (2 ** (ELEM_W - 1)) - 1) begin
                sat_row[l] = {1'b0, {(ELEM_W - 1){1'b1}}};      // 127
            end else if (rd_row[l] < -(2 ** (ELEM_W - 1))) begin
                sat_row[l] = {1'b1, {(ELEM_W - 1){1'b0}}};      // -128
            end else begin
                sat_row[l] = rd_row[l][ELEM_W-1:0];
            end
        end
    end

    // Buffer write lands one cycle after the read
    always_ff @(posedge clk) begin
        st_wr.en   <= acc_rd.en;
        st_wr.addr <= acc_rd.ub_addr;
        st_wr.data <= sat_row;
        if (reset) begin
            st_wr.en <= 1'b0;
        end
    end

endmodule

/* design/mac_column.sv */
`timescale 1ns/100ps

module mac_column #(
    parameter int COL = 0               // Output lane of this column
) (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        wt_wr_en,
    input  logic [tpu_pkg::WT_AW-1:0]   wt_wr_addr,
    input  tpu_pkg::elem_t              wt_wr_data,
    input  tpu_pkg::row_t               row,
    output tpu_pkg::acc_t               psum,
    output logic                        out_valid,
    output logic [tpu_pkg::ACC_AW-1:0]  out_acc_addr,
    output logic                        out_clear
);

    import tpu_pkg::*;

    elem_t w [LANES];   // W[i][COL]
    acc_t  sum;

    // Weight load, only the entries of this column
    always_ff @(posedge clk) begin
        if (wt_wr_en && int'(wt_wr_addr[WT_AW/2-1:0]) == COL) begin
            w[wt_wr_addr[WT_AW-1:WT_AW/2]] <= wt_wr_data;
        end
    end

    // Signed dot product of the row with this weight column
    always_comb begin
        sum = '0;
        for (int i = 0; i < LANES; i++) begin
            sum = sum + row.data[i] * w[i];     // Products widen to ACC_W
        end
    end

    always_ff @(posedge clk) begin
        psum         <= sum;
        out_valid    <= row.valid;
        out_acc_addr <= row.acc_addr;
        out_clear    <= row.clear;
        if (reset) begin
            out_valid <= 1'b0;
        end
    end

endmodule

/* design/act_feeder.sv */
`timescale 1ns/100ps

module act_feeder (
    input  logic                       clk,
    input  logic                       reset,
    input  logic [tpu_pkg::ROW_W-1:0]  rd_data,
    input  logic                       rd_valid,
    input  tpu_pkg::mm_tag_t           mm_tag,
    output tpu_pkg::row_t              row
);

    import tpu_pkg::*;

    mm_tag_t tag_q;     // Tag aligned with the buffer data

    always_ff @(posedge clk) begin
        tag_q        <= mm_tag;
        // A host read owns the port that cycle, so its data is dropped here
        row.valid    <= tag_q.valid & ~rd_valid;
        row.acc_addr <= tag_q.acc_addr;
        row.clear    <= tag_q.clear;
        row.data     <= rd_data;
        if (reset) begin
            tag_q.valid <= 1'b0;
            row.valid   <= 1'b0;
        end
    end

endmodule

/* design/unified_buffer.sv */
`timescale 1ns/100ps

module unified_buffer (
    input  logic                       clk,
    input  logic                       reset,
    input  tpu_pkg::ub_wr_t            host_wr,
    input  tpu_pkg::ub_rd_t            host_rd,
    input  tpu_pkg::ub_rd_t            seq_rd,
    input  tpu_pkg::ub_wr_t            st_wr,
    output logic [tpu_pkg::ROW_W-1:0]  rd_data,
    output logic                       rd_valid    // Host read data only
);

    import tpu_pkg::*;

    logic [ROW_W-1:0] mem [UB_DEPTH];
    ub_wr_t           wr;
    ub_rd_t           rd;

    // Host wins both ports
    assign wr = host_wr.en ? host_wr : st_wr;
    assign rd = host_rd.en ? host_rd : seq_rd;

    always_ff @(posedge clk) begin
        if (wr.en) begin
            mem[wr.addr] <= wr.data;
        end
    end

    // ==================================================================
    // Registered read, data one cycle after the request
    // ==================================================================
    always_ff @(posedge clk) begin
        if (rd.en) begin
            rd_data <= mem[rd.addr];
        end
        rd_valid <= host_rd.en;     // Sequencer reads are flagged by their tag
        if (reset) begin
            rd_valid <= 1'b0;
        end
    end

endmodule

/* design/tpu_pkg.sv */
package tpu_pkg;

    // ==================================================================
    // Array and memory sizes
    // ==================================================================
    localparam int LANES        = 4;    // Columns and elements per row
    localparam int ELEM_W       = 8;    // Signed activation or weight
    localparam int ROW_W        = 32;   // One buffer row
    localparam int ACC_W        = 20;   // Accumulator lane
    localparam int UB_DEPTH     = 256;
    localparam int UB_AW        = 8;
    localparam int ACC_DEPTH    = 16;
    localparam int ACC_AW       = 4;
    localparam int IMEM_DEPTH   = 32;
    localparam int IMEM_AW      = 5;
    localparam int WT_AW        = 4;    // Row index on top, column below
    localparam int DRAIN_CYCLES = 3;    // Buffer, feeder and column stages

    typedef logic signed [ELEM_W-1:0] elem_t;
    typedef logic signed [ACC_W-1:0]  acc_t;

    // ==================================================================
    // Instruction formats
    // ==================================================================
    typedef enum logic [3:0] {
        OP_NOP    = 4'h0,
        OP_MATMUL = 4'h1,
        OP_ST_UB  = 4'h2,
        OP_HALT   = 4'h3
    } opcode_e;

    typedef struct packed {
        opcode_e           opcode;      // Bits 31 to 28 in both formats
        logic [UB_AW-1:0]  ub_addr;     // First activation row
        logic [4:0]        rows;        // 1 to 16
        logic [ACC_AW-1:0] acc_addr;    // First accumulator row
        logic              clear;       // Overwrite instead of add
        logic [9:0]        pad;
    } matmul_instr_t;

    typedef struct packed {
        opcode_e           opcode;
        logic [ACC_AW-1:0] acc_addr;    // Source accumulator row
        logic [UB_AW-1:0]  ub_addr;     // Destination buffer row
        logic [4:0]        rows;
        logic [10:0]       pad;
    } store_instr_t;

    typedef union packed {
        matmul_instr_t mm;
        store_instr_t  st;
    } instr_u;

    // ==================================================================
    // Connections between blocks
    // ==================================================================
    typedef struct packed {
        logic             en;
        logic [UB_AW-1:0] addr;
        logic [ROW_W-1:0] data;
    } ub_wr_t;

    typedef struct packed {
        logic             en;
        logic [UB_AW-1:0] addr;
    } ub_rd_t;

    typedef struct packed {
        logic              valid;       // Read belongs to a MATMUL
        logic [ACC_AW-1:0] acc_addr;
        logic              clear;
    } mm_tag_t;

    typedef struct packed {
        logic              en;
        logic [ACC_AW-1:0] acc_addr;
        logic [UB_AW-1:0]  ub_addr;     // Where the saturated row lands
    } acc_rd_t;

    typedef struct packed {
        logic              valid;
        logic [ACC_AW-1:0] acc_addr;
        logic              clear;
        elem_t [LANES-1:0] data;        // Lane 0 in the low byte
    } row_t;

    typedef acc_t [LANES-1:0] psum_t;

endpackage
